//--- hw/eth_stats_pkg.sv
package eth_stats_pkg;

	// One observed beat of a MAC stream
	typedef struct packed {
		logic beat;
		logic last;
		logic user;
	} axis_mon_t;

	// Finished frame, length in bytes
	typedef struct packed {
		logic [16:0] length;
		logic        good;
	} frame_rec_t;

	// Totals of one direction
	typedef struct packed {
		logic [63:0] bytes;
		logic [63:0] good;
		logic [63:0] bad;
	} stats_t;

	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [3:0]  addr;
		logic [31:0] wdata;
	} reg_req_t;

	// First word of every log packet
	typedef struct packed {
		logic [15:0] log_id;
		logic [15:0] overflow;
		logic [31:0] reserved;
	} log_hdr_t;

	typedef union packed {
		log_hdr_t    hdr;
		logic [63:0] raw;
	} log_word_u;

	typedef struct packed {
		log_word_u data;
		logic      last;
		logic      valid;
	} log_beat_t;

	localparam int LOG_WORDS = 8;

	// Control register bits
	localparam int CTRL_ENABLE = 0;
	localparam int CTRL_SRST = 1;
	localparam int CTRL_LOG_EN = 2;

	// Register map
	localparam logic [3:0] REG_CTRL = 4'd0;
	localparam logic [3:0] REG_LOG_ID = 4'd1;
	localparam logic [3:0] REG_PERIOD = 4'd2;
	localparam logic [3:0] REG_OVERFLOW = 4'd3;
	localparam logic [3:0] REG_TX_BYTES_LO = 4'd4;
	localparam logic [3:0] REG_TX_BYTES_HI = 4'd5;
	localparam logic [3:0] REG_TX_GOOD_LO = 4'd6;
	localparam logic [3:0] REG_TX_GOOD_HI = 4'd7;
	localparam logic [3:0] REG_TX_BAD_LO = 4'd8;
	localparam logic [3:0] REG_TX_BAD_HI = 4'd9;
	localparam logic [3:0] REG_RX_BYTES_LO = 4'd10;
	localparam logic [3:0] REG_RX_BYTES_HI = 4'd11;
	localparam logic [3:0] REG_RX_GOOD_LO = 4'd12;
	localparam logic [3:0] REG_RX_GOOD_HI = 4'd13;
	localparam logic [3:0] REG_RX_BAD_LO = 4'd14;
	localparam logic [3:0] REG_RX_BAD_HI = 4'd15;

endpackage

//--- hw/eth_frame_meter.sv
`timescale 1ns/10ps

module eth_frame_meter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   srst,
	input  eth_stats_pkg::axis_mon_t mon,
	output eth_stats_pkg::frame_rec_t rec,
	output logic                   rec_valid
);

	// Beats seen so far in the current frame
	logic [16:0] beat_cnt;
	logic [16:0] cnt_next;
	logic        frame_end;

	// Count including this beat, held at the 17-bit max
	always_comb begin
		if (beat_cnt == '1) begin
			cnt_next = beat_cnt;
		end else begin
			cnt_next = beat_cnt + 17'd1;
		end
	end

	assign frame_end = mon.beat & mon.last;

	always_ff @(posedge clk) begin
		if (!rst_n || srst) begin
			beat_cnt <= '0;
			rec_valid <= 1'b0;
		end else begin
			rec_valid <= frame_end;
			if (mon.beat) begin
				// Restart on the last beat
				if (mon.last) begin
					beat_cnt <= '0;
				end else begin
					beat_cnt <= cnt_next;
				end
			end
		end
	end

	// Frame record, qualified by rec_valid
	always_ff @(posedge clk) begin
		if (frame_end) begin
			rec.length <= cnt_next;
			// user flags an errored frame
			rec.good <= ~mon.user;
		end
	end

endmodule

//--- hw/eth_stats_adder.sv
`timescale 1ns/10ps

module eth_stats_adder (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      srst,
	input  logic                      count_en,
	input  logic                      rec_valid,
	input  eth_stats_pkg::frame_rec_t rec,
	output eth_stats_pkg::stats_t     totals
);

	logic        accept;
	logic [63:0] rec_bytes;

	// Records outside the counting window are dropped
	assign accept = rec_valid & count_en;
	assign rec_bytes = 64'(rec.length);

	always_ff @(posedge clk) begin
		if (!rst_n || srst) begin
			totals <= '0;
		end else if (accept) begin
			totals.bytes <= totals.bytes + rec_bytes;
			if (rec.good) begin
				totals.good <= totals.good + 64'd1;
			end else begin
				totals.bad <= totals.bad + 64'd1;
			end
		end
	end

endmodule

//--- hw/eth_sample_timer.sv
`timescale 1ns/10ps

module eth_sample_timer #(
	parameter int TIMER_WIDTH = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   srst,
	input  logic                   run,
	input  logic [TIMER_WIDTH-1:0] sample_period,
	output logic                   trigger
);

	logic [TIMER_WIDTH-1:0] cnt;
	logic [TIMER_WIDTH-1:0] period_m1;

	// A period of 0 behaves like 1
	always_comb begin
		if (sample_period == '0) begin
			period_m1 = '0;
		end else begin
			period_m1 = sample_period - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || srst || !run) begin
			cnt <= '0;
			trigger <= 1'b0;
		end else if (cnt >= period_m1) begin
			// Wrap also catches a period shortened on the fly
			cnt <= '0;
			trigger <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			trigger <= 1'b0;
		end
	end

endmodule

//--- hw/eth_stats_log.sv
`timescale 1ns/10ps

module eth_stats_log (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     srst,
	input  logic                     trigger,
	input  logic                     log_enable,
	input  logic                     log_ready,
	input  logic [15:0]              log_id,
	input  logic [63:0]              current_time,
	input  eth_stats_pkg::stats_t    tx_stats,
	input  eth_stats_pkg::stats_t    rx_stats,
	output eth_stats_pkg::log_beat_t log_out,
	output logic [15:0]              overflow_count
);

	import eth_stats_pkg::*;

	localparam int IDX_W = $clog2(LOG_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LOG_WORDS - 1);

	// Captured packet, one word per slot
	log_word_u [LOG_WORDS-1:0] snap;

	logic             busy;
	logic [IDX_W-1:0] idx;
	logic             accept;
	logic             xfer;
	logic             word_last;

	assign accept = trigger & log_enable & ~busy;
	assign xfer = busy & log_ready;
	assign word_last = (idx == LAST_IDX);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			idx <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			idx <= '0;
		end else if (xfer) begin
			if (word_last) begin
				busy <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Snapshot of the header, time and all six totals
	always_ff @(posedge clk) begin
		if (accept) begin
			snap[0].hdr <= '{log_id: log_id, overflow: overflow_count, reserved: 32'd0};
			snap[1].raw <= current_time;
			snap[2].raw <= tx_stats.bytes;
			snap[3].raw <= tx_stats.good;
			snap[4].raw <= tx_stats.bad;
			snap[5].raw <= rx_stats.bytes;
			snap[6].raw <= rx_stats.good;
			snap[7].raw <= rx_stats.bad;
		end
	end

	// Triggers lost to a packet still in flight
	always_ff @(posedge clk) begin
		if (!rst_n || srst) begin
			overflow_count <= '0;
		end else if (trigger && busy && overflow_count != '1) begin
			overflow_count <= overflow_count + 16'd1;
		end
	end

	// Words come straight from the snapshot, so they hold under stall
	always_comb begin
		log_out.data = snap[idx];
		log_out.last = word_last;
		log_out.valid = busy;
	end

endmodule

//--- hw/eth_stats_regs.sv
`timescale 1ns/10ps

module eth_stats_regs #(
	parameter int TIMER_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  eth_stats_pkg::reg_req_t reg_req,
	output logic [31:0]             reg_rdata,
	output logic                    reg_rvalid,
	output logic                    enable,
	output logic                    srst,
	output logic                    log_enable,
	output logic [15:0]             log_id,
	output logic [TIMER_WIDTH-1:0]  sample_period,
	input  eth_stats_pkg::stats_t   tx_stats,
	input  eth_stats_pkg::stats_t   rx_stats,
	input  logic [15:0]             overflow_count
);

	import eth_stats_pkg::*;

	logic [31:0] rd_mux;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable <= 1'b0;
			srst <= 1'b0;
			log_enable <= 1'b0;
			log_id <= '0;
			sample_period <= '0;
		end else begin
			// srst only lasts one cycle
			srst <= 1'b0;
			if (reg_req.wr) begin
				case (reg_req.addr)
					REG_CTRL: begin
						enable <= reg_req.wdata[CTRL_ENABLE];
						srst <= reg_req.wdata[CTRL_SRST];
						log_enable <= reg_req.wdata[CTRL_LOG_EN];
					end
					REG_LOG_ID: log_id <= reg_req.wdata[15:0];
					REG_PERIOD: sample_period <= reg_req.wdata[TIMER_WIDTH-1:0];
					default: ;
				endcase
			end
		end
	end

	// Read mux, srst always reads back as zero
	always_comb begin
		rd_mux = '0;
		case (reg_req.addr)
			REG_CTRL: begin
				rd_mux[CTRL_ENABLE] = enable;
				rd_mux[CTRL_LOG_EN] = log_enable;
			end
			REG_LOG_ID: rd_mux = 32'(log_id);
			REG_PERIOD: rd_mux = 32'(sample_period);
			REG_OVERFLOW: rd_mux = 32'(overflow_count);
			REG_TX_BYTES_LO: rd_mux = tx_stats.bytes[31:0];
			REG_TX_BYTES_HI: rd_mux = tx_stats.bytes[63:32];
			REG_TX_GOOD_LO: rd_mux = tx_stats.good[31:0];
			REG_TX_GOOD_HI: rd_mux = tx_stats.good[63:32];
			REG_TX_BAD_LO: rd_mux = tx_stats.bad[31:0];
			REG_TX_BAD_HI: rd_mux = tx_stats.bad[63:32];
			REG_RX_BYTES_LO: rd_mux = rx_stats.bytes[31:0];
			REG_RX_BYTES_HI: rd_mux = rx_stats.bytes[63:32];
			REG_RX_GOOD_LO: rd_mux = rx_stats.good[31:0];
			REG_RX_GOOD_HI: rd_mux = rx_stats.good[63:32];
			REG_RX_BAD_LO: rd_mux = rx_stats.bad[31:0];
			REG_RX_BAD_HI: rd_mux = rx_stats.bad[63:32];
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reg_rvalid <= 1'b0;
		end else begin
			reg_rvalid <= reg_req.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (reg_req.rd) begin
			reg_rdata <= rd_mux;
		end
	end

endmodule

//--- hw/eth_stats_collector.sv
`timescale 1ns/10ps

module eth_stats_collector #(
	parameter int TIMER_WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [63:0]              current_time,
	input  logic                     time_running,
	input  eth_stats_pkg::reg_req_t  reg_req,
	output logic [31:0]              reg_rdata,
	output logic                     reg_rvalid,
	input  eth_stats_pkg::axis_mon_t tx_mon,
	input  eth_stats_pkg::axis_mon_t rx_mon,
	output eth_stats_pkg::log_beat_t log_out,
	input  logic                     log_ready
);

	import eth_stats_pkg::*;

	logic                   enable;
	logic                   srst;
	logic                   log_enable;
	logic [15:0]            log_id;
	logic [TIMER_WIDTH-1:0] sample_period;
	logic [15:0]            overflow_count;
	logic                   count_en;
	logic                   trigger;

	frame_rec_t tx_rec;
	frame_rec_t rx_rec;
	logic       tx_rec_valid;
	logic       rx_rec_valid;
	stats_t     tx_stats;
	stats_t     rx_stats;

	// Counting window
	assign count_en = enable & time_running;

	eth_frame_meter u_tx_meter (
		.clk       (clk),
		.rst_n     (rst_n),
		.srst      (srst),
		.mon       (tx_mon),
		.rec       (tx_rec),
		.rec_valid (tx_rec_valid)
	);

	eth_stats_adder u_tx_adder (
		.clk       (clk),
		.rst_n     (rst_n),
		.srst      (srst),
		.count_en  (count_en),
		.rec_valid (tx_rec_valid),
		.rec       (tx_rec),
		.totals    (tx_stats)
	);

	eth_frame_meter u_rx_meter (
		.clk       (clk),
		.rst_n     (rst_n),
		.srst      (srst),
		.mon       (rx_mon),
		.rec       (rx_rec),
		.rec_valid (rx_rec_valid)
	);

	eth_stats_adder u_rx_adder (
		.clk       (clk),
		.rst_n     (rst_n),
		.srst      (srst),
		.count_en  (count_en),
		.rec_valid (rx_rec_valid),
		.rec       (rx_rec),
		.totals    (rx_stats)
	);

	eth_sample_timer #(
		.TIMER_WIDTH (TIMER_WIDTH)
	) u_timer (
		.clk           (clk),
		.rst_n         (rst_n),
		.srst          (srst),
		.run           (count_en),
		.sample_period (sample_period),
		.trigger       (trigger)
	);

	eth_stats_log u_log (
		.clk            (clk),
		.rst_n          (rst_n),
		.srst           (srst),
		.trigger        (trigger),
		.log_enable     (log_enable),
		.log_ready      (log_ready),
		.log_id         (log_id),
		.current_time   (current_time),
		.tx_stats       (tx_stats),
		.rx_stats       (rx_stats),
		.log_out        (log_out),
		.overflow_count (overflow_count)
	);

	eth_stats_regs #(
		.TIMER_WIDTH (TIMER_WIDTH)
	) u_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.reg_req        (reg_req),
		.reg_rdata      (reg_rdata),
		.reg_rvalid     (reg_rvalid),
		.enable         (enable),
		.srst           (srst),
		.log_enable     (log_enable),
		.log_id         (log_id),
		.sample_period  (sample_period),
		.tx_stats       (tx_stats),
		.rx_stats       (rx_stats),
		.overflow_count (overflow_count)
	);

endmodule

//--- tests/tb_eth_stats_collector.sv
`timescale 1ns/10ps

module tb_eth_stats_collector;

	import eth_stats_pkg::*;

	// Roughly four times the length of all tests
	localparam int CYCLE_LIMIT = 20000;

	logic        clk;
	logic        rst_n;
	logic [63:0] current_time;
	logic        time_running;
	reg_req_t    reg_req;
	logic [31:0] reg_rdata;
	logic        reg_rvalid;
	axis_mon_t   tx_mon;
	axis_mon_t   rx_mon;
	log_beat_t   log_out;
	logic        log_ready;

	integer      seed;
	int          err_cnt;
	int          test_base;
	int          tests_failed;
	int          cycle_cnt;
	// Reference totals in register order, tx bytes, good and bad then rx
	logic [63:0] m_tot [6];
	logic [63:0] reg_tot [6];
	logic [63:0] pkt [LOG_WORDS];
	logic        model_en;
	logic        model_run;

	eth_stats_collector #(
		.TIMER_WIDTH (32)
	) dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.current_time (current_time),
		.time_running (time_running),
		.reg_req      (reg_req),
		.reg_rdata    (reg_rdata),
		.reg_rvalid   (reg_rvalid),
		.tx_mon       (tx_mon),
		.rx_mon       (rx_mon),
		.log_out      (log_out),
		.log_ready    (log_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Free running time base
	always @(negedge clk) begin
		current_time <= current_time + 64'd1;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	function automatic string tot_name(input int k);
		case (k)
			0: return "tx_bytes";
			1: return "tx_good";
			2: return "tx_bad";
			3: return "rx_bytes";
			4: return "rx_good";
			default: return "rx_bad";
		endcase
	endfunction

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clk);
		reg_req.wr = 1'b1;
		reg_req.addr = addr;
		reg_req.wdata = data;
		@(negedge clk);
		reg_req.wr = 1'b0;
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
		@(negedge clk);
		assert (!reg_rvalid) else begin
			$display("ERROR t=%0t: reg_rvalid stayed high past its read", $time);
			err_cnt++;
		end
		reg_req.rd = 1'b1;
		reg_req.addr = addr;
		@(negedge clk);
		reg_req.rd = 1'b0;
		assert (reg_rvalid) else begin
			$display("ERROR t=%0t: reg_rvalid not high on the cycle after rd", $time);
			err_cnt++;
		end
		data = reg_rdata;
	endtask

	task automatic read64(input logic [3:0] addr_lo, output logic [63:0] data);
		logic [31:0] lo;
		logic [31:0] hi;
		reg_read(addr_lo, lo);
		reg_read(addr_lo + 4'd1, hi);
		data = {hi, lo};
	endtask

	task automatic read_totals();
		for (int k = 0; k < 6; k++) begin
			read64(REG_TX_BYTES_LO + 4'(2 * k), reg_tot[k]);
		end
	endtask

	task automatic check_totals();
		read_totals();
		for (int k = 0; k < 6; k++) begin
			check_value(tot_name(k), reg_tot[k], m_tot[k]);
		end
	endtask

	task automatic send_frame(input logic to_rx, input int len, input logic err);
		axis_mon_t m;
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			m.beat = 1'b1;
			m.last = (i == len - 1);
			// Error flag rides on the closing beat
			m.user = err && (i == len - 1);
			if (to_rx) begin
				rx_mon = m;
			end else begin
				tx_mon = m;
			end
		end
		@(negedge clk);
		tx_mon = '0;
		rx_mon = '0;
	endtask

	task automatic send_traffic(input int n);
		int   len;
		logic err;
		for (int i = 0; i < n; i++) begin
			for (int d = 0; d < 2; d++) begin
				len = ($random(seed) & 63) + 1;
				err = (($random(seed) & 3) == 0);
				send_frame(d[0], len, err);
				if (model_en && model_run) begin
					m_tot[3 * d] += 64'(len);
					if (err) begin
						m_tot[3 * d + 2] += 64'd1;
					end else begin
						m_tot[3 * d + 1] += 64'd1;
					end
				end
			end
		end
		repeat (3) @(negedge clk);
	endtask

	// Collects one full packet into pkt as its words transfer
	task automatic capture_packet();
		int n;
		int waited;
		n = 0;
		waited = 0;
		while (n < LOG_WORDS && waited < 400) begin
			@(negedge clk);
			waited++;
			if (log_out.valid && log_ready) begin
				pkt[n] = log_out.data.raw;
				assert (log_out.last == (n == LOG_WORDS - 1)) else begin
					$display("ERROR t=%0t: last flag wrong on log word %0d", $time, n);
					err_cnt++;
				end
				n++;
			end
		end
		assert (n == LOG_WORDS) else begin
			$display("ERROR t=%0t: log packet ended after %0d words", $time, n);
			err_cnt++;
		end
	endtask

	task automatic begin_test();
		test_base = err_cnt;
	endtask

	task automatic end_test(input int num, input string name);
		if (err_cnt == test_base) begin
			$display("Test %0d %s: ok", num, name);
		end else begin
			$display("Test %0d %s: %0d errors", num, name, err_cnt - test_base);
			tests_failed++;
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] ov_stall;
		logic [31:0] ov_after;
		logic [63:0] prev_time;
		logic [63:0] held;
		logic        held_last;
		log_hdr_t    hdr;
		int          n;

		seed = 32'h37c8_3f25;
		err_cnt = 0;
		tests_failed = 0;
		cycle_cnt = 0;
		rst_n = 1'b0;
		current_time = 64'd0;
		time_running = 1'b1;
		reg_req = '0;
		tx_mon = '0;
		rx_mon = '0;
		log_ready = 1'b1;
		model_en = 1'b0;
		model_run = 1'b1;
		for (int k = 0; k < 6; k++) begin
			m_tot[k] = 64'd0;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		begin_test();
		assert (!log_out.valid && !reg_rvalid) else begin
			$display("ERROR t=%0t: valid outputs not low after reset", $time);
			err_cnt++;
		end
		for (int a = 0; a < 16; a++) begin
			reg_read(4'(a), rd);
			check_value($sformatf("reg[%0d]", a), 64'(rd), 64'd0);
		end
		end_test(1, "reset state");

		begin_test();
		reg_write(REG_CTRL, 32'h1);
		model_en = 1'b1;
		send_traffic(20);
		check_totals();
		end_test(2, "random traffic");

		begin_test();
		reg_write(REG_CTRL, 32'h0);
		model_en = 1'b0;
		send_traffic(4);
		check_totals();
		reg_write(REG_CTRL, 32'h1);
		model_en = 1'b1;
		time_running = 1'b0;
		model_run = 1'b0;
		send_traffic(4);
		check_totals();
		time_running = 1'b1;
		model_run = 1'b1;
		end_test(3, "counting window");

		begin_test();
		reg_write(REG_PERIOD, 32'd40);
		reg_write(REG_LOG_ID, 32'h0000_a5c3);
		check_totals();
		reg_write(REG_CTRL, 32'h5);
		prev_time = 64'd0;
		for (int p = 0; p < 3; p++) begin
			capture_packet();
			hdr = pkt[0];
			check_value("hdr.log_id", 64'(hdr.log_id), 64'ha5c3);
			check_value("hdr.reserved", 64'(hdr.reserved), 64'd0);
			for (int k = 0; k < 6; k++) begin
				check_value({"log ", tot_name(k)}, pkt[2 + k], m_tot[k]);
			end
			assert (p == 0 || pkt[1] > prev_time) else begin
				$display("ERROR t=%0t: log time word did not increase", $time);
				err_cnt++;
			end
			prev_time = pkt[1];
		end
		end_test(4, "log packets");

		begin_test();
		reg_write(REG_PERIOD, 32'd12);
		log_ready = 1'b0;
		n = 0;
		while (!log_out.valid && n < 100) begin
			@(negedge clk);
			n++;
		end
		held = log_out.data.raw;
		held_last = log_out.last;
		repeat (50) begin
			@(negedge clk);
			check_value("log_out.valid", 64'(log_out.valid), 64'd1);
			check_value("log_out.data", log_out.data.raw, held);
			check_value("log_out.last", 64'(log_out.last), 64'(held_last));
		end
		reg_read(REG_OVERFLOW, ov_stall);
		assert (ov_stall != 0) else begin
			$display("ERROR t=%0t: overflow count stayed zero under stall", $time);
			err_cnt++;
		end
		log_ready = 1'b1;
		// Let the stalled packet finish
		n = 0;
		while (!(log_out.valid && log_out.last) && n < 50) begin
			@(negedge clk);
			n++;
		end
		capture_packet();
		hdr = pkt[0];
		reg_read(REG_OVERFLOW, ov_after);
		assert (hdr.overflow >= ov_stall[15:0] && hdr.overflow <= ov_after[15:0]) else begin
			$display("ERROR t=%0t: header overflow %0d outside %0d..%0d", $time,
				hdr.overflow, ov_stall, ov_after);
			err_cnt++;
		end
		end_test(5, "back-pressure");

		begin_test();
		reg_write(REG_CTRL, 32'h1);
		// Drain any packet still in flight before the soft reset
		n = 0;
		while (log_out.valid && n < 50) begin
			@(negedge clk);
			n++;
		end
		reg_write(REG_CTRL, 32'h3);
		for (int k = 0; k < 6; k++) begin
			m_tot[k] = 64'd0;
		end
		reg_read(REG_OVERFLOW, rd);
		check_value("overflow_count", 64'(rd), 64'd0);
		check_totals();
		send_traffic(5);
		check_totals();
		end_test(6, "soft reset");

		$display("Summary: 6 tests, %0d failed, %0d check errors", tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
hw/eth_stats_pkg.sv
hw/eth_frame_meter.sv
hw/eth_stats_adder.sv
hw/eth_sample_timer.sv
hw/eth_stats_log.sv
hw/eth_stats_regs.sv
hw/eth_stats_collector.sv
tests/tb_eth_stats_collector.sv

//--- Bender.yml
package:
  name: eth_stats_collector

sources:
  - files:
      - hw/eth_stats_pkg.sv
      - hw/eth_frame_meter.sv
      - hw/eth_stats_adder.sv
      - hw/eth_sample_timer.sv
      - hw/eth_stats_log.sv
      - hw/eth_stats_regs.sv
      - hw/eth_stats_collector.sv
  - target: test
    files:
      - tests/tb_eth_stats_collector.sv
